// ==== Makefile ====
TOP := dbg_brk_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== rtl/dbg_brk_top.sv ====
// Top level of the breakpoint subsystem; connects decoder, breakpoint units and halt control
module dbg_brk_top (
  input  logic                dbg_clk,
  input  logic                dbg_rst,
  // Host command channel
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  dbg_pkg::dbg_cmd_t   cmd,
  // Host response channel
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output logic [15:0]         rsp_data,
  // CPU observation and control
  input  dbg_pkg::cpu_bus_t   cpu_bus,
  output logic                cpu_halt,
  output logic                brk_pnd
);

  import dbg_pkg::*;

  logic [NUM_BRK-1:0][3:0]  brk_reg_wr;
  logic [NUM_BRK-1:0][3:0]  brk_reg_rd;
  logic [NUM_BRK-1:0][15:0] brk_dout;
  logic [NUM_BRK-1:0]       brk_halt;
  logic [NUM_BRK-1:0]       brk_pnd_vec;
  logic                     cpu_reg_wr;
  logic                     cpu_reg_rd;
  logic                     rd_en;
  brk_word_u                wr_data;

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////

  // Busy follows the pending response
  dbg_reg_decode u_decode (
    .dbg_clk    (dbg_clk),
    .dbg_rst    (dbg_rst),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .rsp_busy   (rsp_valid),
    .brk_reg_wr (brk_reg_wr),
    .brk_reg_rd (brk_reg_rd),
    .cpu_reg_wr (cpu_reg_wr),
    .cpu_reg_rd (cpu_reg_rd),
    .rd_en      (rd_en),
    .wr_data    (wr_data)
  );

  // Breakpoint units
  for (genvar u = 0; u < NUM_BRK; u++) begin : g_brk
    dbg_hwbrk u_hwbrk (
      .dbg_clk    (dbg_clk),
      .dbg_rst    (dbg_rst),
      .brk_reg_wr (brk_reg_wr[u]),
      .brk_reg_rd (brk_reg_rd[u]),
      .wr_data    (wr_data),
      .cpu_bus    (cpu_bus),
      .brk_halt   (brk_halt[u]),
      .brk_pnd    (brk_pnd_vec[u]),
      .brk_dout   (brk_dout[u])
    );
  end

  // Halt state and read response
  dbg_halt_ctl u_halt_ctl (
    .dbg_clk     (dbg_clk),
    .dbg_rst     (dbg_rst),
    .brk_halt    (brk_halt),
    .brk_pnd     (brk_pnd_vec),
    .brk_dout    (brk_dout),
    .cpu_reg_wr  (cpu_reg_wr),
    .cpu_reg_rd  (cpu_reg_rd),
    .rd_en       (rd_en),
    .wr_data     (wr_data),
    .rsp_ready   (rsp_ready),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .cpu_halt    (cpu_halt),
    .brk_pnd_any (brk_pnd)
  );

endmodule

// ==== rtl/dbg_halt_ctl.sv ====
// Halt controller; holds the CPU halt state and the host read response
module dbg_halt_ctl (
  input  logic                                 dbg_clk,
  input  logic                                 dbg_rst,
  // From the breakpoint units
  input  logic [dbg_pkg::NUM_BRK-1:0]          brk_halt,
  input  logic [dbg_pkg::NUM_BRK-1:0]          brk_pnd,
  input  logic [dbg_pkg::NUM_BRK-1:0][15:0]    brk_dout,
  // From the decoder
  input  logic                                 cpu_reg_wr,
  input  logic                                 cpu_reg_rd,
  input  logic                                 rd_en,
  input  dbg_pkg::brk_word_u                   wr_data,
  // Response channel
  input  logic                                 rsp_ready,
  output logic                                 rsp_valid,
  output logic [15:0]                          rsp_data,
  // CPU side
  output logic                                 cpu_halt,
  output logic                                 brk_pnd_any
);

  import dbg_pkg::*;

  logic        resume;
  logic [15:0] cpu_word;
  logic [15:0] rd_data;

  ////////////////////////////////////////////////////////////
  // Halt state
  ////////////////////////////////////////////////////////////

  // Resume is a CPU register write with bit 0 set
  assign resume = cpu_reg_wr & wr_data.raw[0];

  // Break request has priority over resume in the same cycle
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      cpu_halt <= 1'b0;
    end else if (|brk_halt) begin
      cpu_halt <= 1'b1;
    end else if (resume) begin
      cpu_halt <= 1'b0;
    end
  end

  assign brk_pnd_any = |brk_pnd;

  ////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////

  // Bit 0 halted, bit 1 any unit pending
  assign cpu_word = {14'h0000, brk_pnd_any, cpu_halt} & {16{cpu_reg_rd}};

  // Unselected sources are zero
  always_comb begin
    rd_data = cpu_word;
    for (int u = 0; u < NUM_BRK; u++) begin
      rd_data = rd_data | brk_dout[u];
    end
  end

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  // Loaded at the accepting edge, held until the host takes it
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      rsp_valid <= 1'b0;
      rsp_data  <= '0;
    end else if (rd_en) begin
      rsp_valid <= 1'b1;
      rsp_data  <= rd_data;
    end else if (rsp_valid && rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

endmodule

// ==== rtl/dbg_hwbrk.sv ====
// One hardware breakpoint/watchpoint unit; instantiated once per unit in the top level
module dbg_hwbrk (
  input  logic                dbg_clk,
  input  logic                dbg_rst,
  // Register selects from the decoder
  input  logic [3:0]          brk_reg_wr,
  input  logic [3:0]          brk_reg_rd,
  input  dbg_pkg::brk_word_u  wr_data,
  // Observed CPU activity
  input  dbg_pkg::cpu_bus_t   cpu_bus,
  // Break request, sticky pending flag, read data
  output logic                brk_halt,
  output logic                brk_pnd,
  output logic [15:0]         brk_dout
);

  import dbg_pkg::*;

  brk_ctl_t    ctl_q;
  brk_ctl_t    ctl_wr;
  brk_stat_t   stat_q;
  brk_stat_t   stat_set;
  brk_stat_t   stat_clr;
  logic [15:0] addr0_q;
  logic [15:0] addr1_q;

  logic [15:0] cmp_addr;
  logic        cmp_vld;
  logic        acc_rd;
  logic        acc_wr;
  logic        hit_addr0;
  logic        hit_addr1;
  logic        hit_range;

  ////////////////////////////////////////////////////////////
  // Control register
  ////////////////////////////////////////////////////////////

  // Keep only the five defined bits
  always_comb begin
    ctl_wr             = '0;
    ctl_wr.range_mode  = wr_data.ctl.range_mode & BRK_RANGE_EN;
    ctl_wr.inst_en     = wr_data.ctl.inst_en;
    ctl_wr.break_en    = wr_data.ctl.break_en;
    ctl_wr.access_mode = wr_data.ctl.access_mode;
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      ctl_q <= '0;
    end else if (brk_reg_wr[REG_CTL]) begin
      ctl_q <= ctl_wr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      addr0_q <= '0;
      addr1_q <= '0;
    end else begin
      if (brk_reg_wr[REG_ADDR0]) begin
        addr0_q <= wr_data.raw;
      end
      if (brk_reg_wr[REG_ADDR1]) begin
        addr1_q <= wr_data.raw;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparators
  ////////////////////////////////////////////////////////////

  // Instruction flow watches pc, data flow the memory address bus
  assign cmp_addr = ctl_q.inst_en ? cpu_bus.pc : cpu_bus.mab;
  assign cmp_vld  = ctl_q.inst_en ? cpu_bus.decode_noirq : cpu_bus.mb_en;

  // Every decode is a read; data cycles split on the write strobes
  assign acc_rd = cmp_vld & (ctl_q.inst_en | ~|cpu_bus.mb_wr);
  assign acc_wr = cmp_vld & ~ctl_q.inst_en & |cpu_bus.mb_wr;

  // Equality only outside range mode
  assign hit_addr0 = ~ctl_q.range_mode & (cmp_addr == addr0_q);
  assign hit_addr1 = ~ctl_q.range_mode & (cmp_addr == addr1_q);

  // Inclusive bounds
  assign hit_range = ctl_q.range_mode & BRK_RANGE_EN
                   & (cmp_addr >= addr0_q) & (cmp_addr <= addr1_q);

  ////////////////////////////////////////////////////////////
  // Status register
  ////////////////////////////////////////////////////////////

  // Flags raised this cycle, gated by access mode
  always_comb begin
    stat_set          = '0;
    stat_set.addr0_rd = ctl_q.access_mode[0] & acc_rd & hit_addr0;
    stat_set.addr0_wr = ctl_q.access_mode[1] & acc_wr & hit_addr0;
    stat_set.addr1_rd = ctl_q.access_mode[0] & acc_rd & hit_addr1;
    stat_set.addr1_wr = ctl_q.access_mode[1] & acc_wr & hit_addr1;
    stat_set.range_rd = ctl_q.access_mode[0] & acc_rd & hit_range;
    stat_set.range_wr = ctl_q.access_mode[1] & acc_wr & hit_range;
  end

  // Write-one-to-clear mask, only on a STAT write
  assign stat_clr = brk_reg_wr[REG_STAT] ? wr_data.stat : '0;

  // A new match wins over a clear of the same bit
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      stat_q <= '0;
    end else begin
      stat_q <= (stat_q & ~stat_clr) | stat_set;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign brk_pnd  = |stat_q;
  assign brk_halt = ctl_q.break_en & |stat_set;

  // Zero unless this unit is read
  assign brk_dout = (ctl_q   & {16{brk_reg_rd[REG_CTL]}})
                  | (stat_q  & {16{brk_reg_rd[REG_STAT]}})
                  | (addr0_q & {16{brk_reg_rd[REG_ADDR0]}})
                  | (addr1_q & {16{brk_reg_rd[REG_ADDR1]}});

endmodule

// ==== rtl/dbg_pkg.sv ====
// Shared definitions for the breakpoint subsystem; imported by every RTL module
package dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////

  // Number of breakpoint/watchpoint units
  localparam int NUM_BRK = 2;

  // Range mode support, 0 strips range control and status
  localparam logic BRK_RANGE_EN = 1'b1;

  // Register index inside one unit
  localparam logic [1:0] REG_CTL   = 2'd0;
  localparam logic [1:0] REG_STAT  = 2'd1;
  localparam logic [1:0] REG_ADDR0 = 2'd2;
  localparam logic [1:0] REG_ADDR1 = 2'd3;

  // Unit slot that holds the CPU control register
  localparam logic [1:0] UNIT_CPU = 2'd2;

  ////////////////////////////////////////////////////////////
  // Register layouts
  ////////////////////////////////////////////////////////////

  // Control word, access_mode bit 1 detects writes, bit 0 reads
  typedef struct packed {
    logic [10:0] rsvd;
    logic        range_mode;
    logic        inst_en;
    logic        break_en;
    logic [1:0]  access_mode;
  } brk_ctl_t;

  // Sticky status flags
  typedef struct packed {
    logic [9:0] rsvd;
    logic       range_wr;
    logic       range_rd;
    logic       addr1_wr;
    logic       addr1_rd;
    logic       addr0_wr;
    logic       addr0_rd;
  } brk_stat_t;

  // One host data word seen as address, control fields or clear mask
  typedef union packed {
    logic [15:0] raw;
    brk_ctl_t    ctl;
    brk_stat_t   stat;
  } brk_word_u;

  // Host command, unit in addr[3:2] and register in addr[1:0]
  typedef struct packed {
    logic [3:0] addr;
    logic       write;
    brk_word_u  data;
  } dbg_cmd_t;

  // Observed CPU signals
  typedef struct packed {
    logic        decode_noirq;
    logic [15:0] pc;
    logic [15:0] mab;
    logic        mb_en;
    logic [1:0]  mb_wr;
  } cpu_bus_t;

endpackage

// ==== rtl/dbg_reg_decode.sv ====
// Host command decoder; turns accepted commands into per-unit register selects
module dbg_reg_decode (
  input  logic                                      dbg_clk,
  input  logic                                      dbg_rst,
  // Host command channel
  input  logic                                      cmd_valid,
  output logic                                      cmd_ready,
  input  dbg_pkg::dbg_cmd_t                         cmd,
  // Response register still waiting for the host
  input  logic                                      rsp_busy,
  // Breakpoint unit selects
  output logic [dbg_pkg::NUM_BRK-1:0][3:0]          brk_reg_wr,
  output logic [dbg_pkg::NUM_BRK-1:0][3:0]          brk_reg_rd,
  // CPU control register strobes
  output logic                                      cpu_reg_wr,
  output logic                                      cpu_reg_rd,
  // Any accepted read, loads the response
  output logic                                      rd_en,
  output dbg_pkg::brk_word_u                        wr_data
);

  import dbg_pkg::*;

  logic       accept;
  logic       rd_acc_q;
  logic [1:0] unit_sel;
  logic [1:0] reg_sel;
  logic [3:0] reg_onehot;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Read accepted last cycle, covers the edge loading the response
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      rd_acc_q <= 1'b0;
    end else begin
      rd_acc_q <= accept & ~cmd.write;
    end
  end

  assign cmd_ready = ~rsp_busy & ~rd_acc_q;
  assign accept    = cmd_valid & cmd_ready;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign unit_sel   = cmd.addr[3:2];
  assign reg_sel    = cmd.addr[1:0];
  assign reg_onehot = 4'b0001 << reg_sel;

  // One-hot strobes, only in the handshake cycle
  always_comb begin
    for (int u = 0; u < NUM_BRK; u++) begin
      brk_reg_wr[u] = '0;
      brk_reg_rd[u] = '0;
      if (accept && (unit_sel == 2'(u))) begin
        if (cmd.write) begin
          brk_reg_wr[u] = reg_onehot;
        end else begin
          brk_reg_rd[u] = reg_onehot;
        end
      end
    end
  end

  // CPU control register lives at register 0 of its slot
  assign cpu_reg_wr = accept & cmd.write & (unit_sel == UNIT_CPU) & (reg_sel == REG_CTL);
  assign cpu_reg_rd = accept & ~cmd.write & (unit_sel == UNIT_CPU) & (reg_sel == REG_CTL);

  // Unmapped reads still answer, with zero data
  assign rd_en   = accept & ~cmd.write;
  assign wr_data = cmd.data;

endmodule

// ==== verification/dbg_brk_chk.sv ====
// Concurrent checks on the host channels and the halt state; bound into the subsystem top level
module dbg_brk_chk (
  input logic                         dbg_clk,
  input logic                         dbg_rst,
  input logic                         cmd_ready,
  input logic                         rsp_valid,
  input logic                         rsp_ready,
  input logic [15:0]                  rsp_data,
  input logic [dbg_pkg::NUM_BRK-1:0]  brk_halt,
  input logic                         cpu_halt,
  input logic                         brk_pnd
);

  ////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////

  // A waiting response keeps its valid and its data
  a_rsp_hold: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else $error("response dropped or changed while the host stalled");

  // No new command while a response is pending
  a_busy: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    rsp_valid |-> !cmd_ready)
    else $error("cmd_ready high with a response pending");

  ////////////////////////////////////////////////////////////
  // Halt state
  ////////////////////////////////////////////////////////////

  // Halt only follows a break request of the previous cycle
  a_halt_cause: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    $rose(cpu_halt) |-> $past(|brk_halt))
    else $error("cpu_halt rose without a break request");

  // Outputs fully known once out of reset
  a_known: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    !$isunknown({cmd_ready, rsp_valid, rsp_data, cpu_halt, brk_pnd}))
    else $error("unknown value on a top level output");

endmodule

bind dbg_brk_top dbg_brk_chk u_chk (
  .dbg_clk   (dbg_clk),
  .dbg_rst   (dbg_rst),
  .cmd_ready (cmd_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_data  (rsp_data),
  .brk_halt  (brk_halt),
  .cpu_halt  (cpu_halt),
  .brk_pnd   (brk_pnd)
);

// ==== verification/dbg_brk_tb.sv ====
// Testbench for the breakpoint subsystem; runs a table of host commands and bus events
module dbg_brk_tb;

  import dbg_pkg::*;

  typedef enum logic [1:0] {STEP_WR, STEP_RD, STEP_BUS} step_kind_t;

  // One table row
  // Data is the write value or the expected read value
  typedef struct packed {
    logic [2:0]  test;
    step_kind_t  kind;
    logic [3:0]  addr;
    logic [15:0] data;
    cpu_bus_t    bus;
    logic        halt;
    logic        pnd;
  } step_t;

  logic        dbg_clk;
  logic        dbg_rst;
  logic        cmd_valid;
  logic        cmd_ready;
  dbg_cmd_t    cmd;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [15:0] rsp_data;
  cpu_bus_t    cpu_bus;
  logic        cpu_halt;
  logic        brk_pnd;

  step_t       steps[$];
  logic [2:0]  tbl_test;
  int          errors;
  int          checks;
  int          cur_step;
  bit          timed_out;
  int          wait_limit = 32;

  dbg_brk_top uut (
    .dbg_clk   (dbg_clk),
    .dbg_rst   (dbg_rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .cpu_bus   (cpu_bus),
    .cpu_halt  (cpu_halt),
    .brk_pnd   (brk_pnd)
  );

  initial begin
    dbg_clk = 1'b0;
    forever #5 dbg_clk = ~dbg_clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR t=%0t %s expected %h actual %h (step %0d)", $time, name, exp, act, cur_step);
    end
  endtask

  // hp packs expected cpu_halt and brk_pnd after the step
  task automatic push_step(input step_kind_t kind, input logic [3:0] addr,
                           input logic [15:0] data, input cpu_bus_t bus, input logic [1:0] hp);
    step_t s;
    s      = '0;
    s.test = tbl_test;
    s.kind = kind;
    s.addr = addr;
    s.data = data;
    s.bus  = bus;
    s.halt = hp[1];
    s.pnd  = hp[0];
    steps.push_back(s);
  endtask

  function automatic cpu_bus_t data_read(input logic [15:0] mab);
    cpu_bus_t b;
    b       = '0;
    b.mab   = mab;
    b.mb_en = 1'b1;
    return b;
  endfunction

  function automatic cpu_bus_t data_write(input logic [15:0] mab, input logic [1:0] wr);
    cpu_bus_t b;
    b       = data_read(mab);
    b.mb_wr = wr;
    return b;
  endfunction

  // Decode at pc with a data write going on at mab
  function automatic cpu_bus_t decode_at(input logic [15:0] pc, input logic [15:0] mab);
    cpu_bus_t b;
    b              = data_write(mab, 2'b11);
    b.decode_noirq = 1'b1;
    b.pc           = pc;
    return b;
  endfunction

  function automatic string test_name(input int t);
    string n;
    case (t)
      1:       n = "reset and readback";
      2:       n = "single address";
      3:       n = "range mode";
      4:       n = "break versus watch";
      5:       n = "clear and resume";
      default: n = "back-pressure";
    endcase
    return n;
  endfunction

  task automatic report_test(input int t, input int n, input int n_err);
    $display("test %0d %s %0d steps, %0d errors", t, test_name(t), n, n_err);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  // Address is unit in bits 3:2 and register in bits 1:0
  // CPU register sits at address 8
  task automatic build_table();
    tbl_test = 3'd1;
    for (int a = 0; a <= 8; a++) begin
      push_step(STEP_RD, 4'(a), 16'h0000, '0, 2'b00);
    end
    push_step(STEP_WR, 4'h0, 16'hffff, '0, 2'b00);
    // Only the five control bits stick
    push_step(STEP_RD, 4'h0, 16'h001f, '0, 2'b00);
    push_step(STEP_WR, 4'h0, 16'h0000, '0, 2'b00);
    push_step(STEP_WR, 4'h2, 16'ha5c3, '0, 2'b00);
    push_step(STEP_RD, 4'h2, 16'ha5c3, '0, 2'b00);
    push_step(STEP_WR, 4'h7, 16'h5a3c, '0, 2'b00);
    push_step(STEP_RD, 4'h7, 16'h5a3c, '0, 2'b00);
    // Unmapped unit 3 drops the write and reads zero
    // Its ADDR1 slot lines up with unit 1 ADDR1 read back later
    push_step(STEP_WR, 4'hf, 16'h1234, '0, 2'b00);
    push_step(STEP_RD, 4'hf, 16'h0000, '0, 2'b00);

    tbl_test = 3'd2;
    push_step(STEP_WR, 4'h2, 16'h0200, '0, 2'b00);
    push_step(STEP_WR, 4'h3, 16'h0300, '0, 2'b00);
    push_step(STEP_WR, 4'h0, 16'h0001, '0, 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h0200), 2'b01);
    // Write cycle ignored in read-only mode
    push_step(STEP_BUS, 4'h0, 16'h0000, data_write(16'h0200, 2'b01), 2'b01);
    push_step(STEP_RD, 4'h1, 16'h0001, '0, 2'b01);
    push_step(STEP_WR, 4'h1, 16'hffff, '0, 2'b00);
    push_step(STEP_WR, 4'h0, 16'h0002, '0, 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h0300), 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_write(16'h0300, 2'b11), 2'b01);
    push_step(STEP_RD, 4'h1, 16'h0008, '0, 2'b01);
    push_step(STEP_WR, 4'h1, 16'hffff, '0, 2'b00);
    // Instruction flow where pc hits addr0 and the data write goes unseen
    push_step(STEP_WR, 4'h0, 16'h000b, '0, 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, decode_at(16'h0200, 16'h0300), 2'b01);
    push_step(STEP_RD, 4'h1, 16'h0001, '0, 2'b01);
    push_step(STEP_WR, 4'h1, 16'hffff, '0, 2'b00);
    push_step(STEP_WR, 4'h0, 16'h0000, '0, 2'b00);

    tbl_test = 3'd3;
    push_step(STEP_WR, 4'h2, 16'h1000, '0, 2'b00);
    push_step(STEP_WR, 4'h3, 16'h10ff, '0, 2'b00);
    push_step(STEP_WR, 4'h0, 16'h0013, '0, 2'b00);
    // Just outside both bounds
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h0fff), 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_write(16'h1100, 2'b01), 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h1000), 2'b01);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_write(16'h10ff, 2'b10), 2'b01);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h1080), 2'b01);
    // Range flags set and equality flags clear
    push_step(STEP_RD, 4'h1, 16'h0030, '0, 2'b01);
    push_step(STEP_WR, 4'h1, 16'h0020, '0, 2'b01);
    push_step(STEP_RD, 4'h1, 16'h0010, '0, 2'b01);
    push_step(STEP_WR, 4'h1, 16'h0010, '0, 2'b00);

    tbl_test = 3'd4;
    // Unit 1 watches writes to 2000
    push_step(STEP_WR, 4'h6, 16'h2000, '0, 2'b00);
    push_step(STEP_WR, 4'h4, 16'h0002, '0, 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_write(16'h2000, 2'b11), 2'b01);
    push_step(STEP_RD, 4'h5, 16'h0002, '0, 2'b01);
    push_step(STEP_RD, 4'h8, 16'h0002, '0, 2'b01);
    push_step(STEP_WR, 4'h5, 16'h0002, '0, 2'b00);
    // Unit 0 breaks on reads of 10ff
    push_step(STEP_WR, 4'h0, 16'h0005, '0, 2'b00);
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h10ff), 2'b11);
    push_step(STEP_RD, 4'h8, 16'h0003, '0, 2'b11);
    push_step(STEP_RD, 4'h5, 16'h0000, '0, 2'b11);

    tbl_test = 3'd5;
    push_step(STEP_BUS, 4'h0, 16'h0000, data_read(16'h1000), 2'b11);
    push_step(STEP_WR, 4'h1, 16'h0004, '0, 2'b11);
    push_step(STEP_RD, 4'h1, 16'h0001, '0, 2'b11);
    push_step(STEP_WR, 4'h1, 16'h0001, '0, 2'b10);
    // Bit 0 clear is no resume
    push_step(STEP_WR, 4'h8, 16'h0000, '0, 2'b10);
    push_step(STEP_WR, 4'h8, 16'h0001, '0, 2'b00);
    push_step(STEP_RD, 4'h8, 16'h0000, '0, 2'b00);

    tbl_test = 3'd6;
    push_step(STEP_RD, 4'h2, 16'h1000, '0, 2'b00);
    push_step(STEP_RD, 4'h3, 16'h10ff, '0, 2'b00);
    push_step(STEP_RD, 4'h6, 16'h2000, '0, 2'b00);
    push_step(STEP_RD, 4'h7, 16'h5a3c, '0, 2'b00);
    push_step(STEP_RD, 4'h4, 16'h0002, '0, 2'b00);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////////////////////////

  // Returns at the transfer edge
  task automatic send_cmd(input logic [3:0] addr, input logic wr, input logic [15:0] data);
    int n;
    bit ok;
    n  = 0;
    ok = 1'b0;
    @(posedge dbg_clk);
    cmd_valid    <= 1'b1;
    cmd.addr     <= addr;
    cmd.write    <= wr;
    cmd.data.raw <= data;
    // Ready only moves at a rising edge
    while (!ok && n < wait_limit) begin
      @(negedge dbg_clk);
      if (cmd_ready) begin
        ok = 1'b1;
      end
      n++;
    end
    if (ok) begin
      @(posedge dbg_clk);
      cmd_valid <= 1'b0;
    end else begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: command at step %0d was never accepted", cur_step);
    end
  endtask

  // Response due one cycle after acceptance and held through a random stall
  task automatic take_rsp(input logic [15:0] exp);
    int stall;
    stall = int'($urandom % 4);
    @(negedge dbg_clk);
    check_value("rsp_valid", 16'h0001, 16'(rsp_valid));
    check_value("rsp_data", exp, rsp_data);
    check_value("cmd_ready", 16'h0000, 16'(cmd_ready));
    repeat (stall) begin
      @(negedge dbg_clk);
      check_value("rsp_valid", 16'h0001, 16'(rsp_valid));
      check_value("rsp_data", exp, rsp_data);
      check_value("cmd_ready", 16'h0000, 16'(cmd_ready));
    end
    @(posedge dbg_clk);
    rsp_ready <= 1'b1;
    @(posedge dbg_clk);
    rsp_ready <= 1'b0;
  endtask

  // One cycle of bus activity followed by idle
  task automatic drive_bus(input cpu_bus_t b);
    @(posedge dbg_clk);
    cpu_bus <= b;
    @(posedge dbg_clk);
    cpu_bus <= '0;
  endtask

  task automatic run_step(input step_t s);
    case (s.kind)
      STEP_WR: send_cmd(s.addr, 1'b1, s.data);
      STEP_RD: begin
        send_cmd(s.addr, 1'b0, 16'h0000);
        if (!timed_out) begin
          take_rsp(s.data);
        end
      end
      default: drive_bus(s.bus);
    endcase
    if (!timed_out) begin
      @(negedge dbg_clk);
      check_value("cpu_halt", 16'(s.halt), 16'(cpu_halt));
      check_value("brk_pnd", 16'(s.pnd), 16'(brk_pnd));
      check_value("rsp_valid", 16'h0000, 16'(rsp_valid));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int cur_test;
    int test_steps;
    int err_base;
    dbg_rst   = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b0;
    cpu_bus   = '0;
    errors    = 0;
    checks    = 0;
    cur_step  = 0;
    timed_out = 1'b0;
    void'($urandom(57));
    build_table();
    repeat (16) @(posedge dbg_clk);
    dbg_rst <= 1'b0;
    // Idle state right after reset
    @(negedge dbg_clk);
    check_value("cmd_ready", 16'h0001, 16'(cmd_ready));
    check_value("rsp_valid", 16'h0000, 16'(rsp_valid));
    check_value("cpu_halt", 16'h0000, 16'(cpu_halt));
    check_value("brk_pnd", 16'h0000, 16'(brk_pnd));
    cur_test   = 1;
    test_steps = 0;
    err_base   = 0;
    for (int i = 0; i < steps.size(); i++) begin
      if (int'(steps[i].test) != cur_test) begin
        report_test(cur_test, test_steps, errors - err_base);
        cur_test   = int'(steps[i].test);
        test_steps = 0;
        err_base   = errors;
      end
      cur_step = i;
      run_step(steps[i]);
      test_steps++;
      if (timed_out) begin
        break;
      end
    end
    report_test(cur_test, test_steps, errors - err_base);
    $display("summary: %0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/dbg_pkg.sv
rtl/dbg_reg_decode.sv
rtl/dbg_hwbrk.sv
rtl/dbg_halt_ctl.sv
rtl/dbg_brk_top.sv
verification/dbg_brk_chk.sv
verification/dbg_brk_tb.sv
